// File: source/ialu_cfg.svh
// Integer ALU configuration
// Data width, shift-amount width and multiplier counter width

`ifndef IALU_CFG_SVH
`define IALU_CFG_SVH

// Operand and result width
`define IALU_XLEN       32

// Low bits of op2 taken as the shift amount
`define IALU_SHAMT_W    5

// Iteration counter of the sequential multiplier
`define IALU_MUL_CNT_W  5

`endif

// File: source/ialu_pkg.sv
// Integer ALU shared types
// Command encoding and the flags of the main subtractor

package ialu_pkg;

    typedef enum logic [4:0] {
        NONE,
        ADD,
        SUB,
        SUB_LT,         // Signed less than
        SUB_LTU,        // Unsigned less than
        SUB_EQ,
        SUB_NE,
        SUB_GE,         // Signed greater or equal
        SUB_GEU,        // Unsigned greater or equal
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        MUL,            // Low word
        MULH,           // High word, signed x signed
        MULHSU,         // High word, signed x unsigned
        MULHU           // High word, unsigned x unsigned
    } ialu_cmd_e;

    typedef struct packed {
        logic zero;
        logic sign;
        logic overflow;
        logic carry;    // Borrow on subtraction
    } ialu_flags_s;

endpackage

// File: source/ialu_req_if.sv
// ALU request bundle
// Valid level, both operands and the command, fanned out to every unit

`include "ialu_cfg.svh"

interface ialu_req_if;

    logic                   vd;     // Held high until rdy
    logic [`IALU_XLEN-1:0]  op1;
    logic [`IALU_XLEN-1:0]  op2;
    ialu_pkg::ialu_cmd_e    cmd;

    modport source (
        output vd, op1, op2, cmd
    );

    modport unit (
        input  vd, op1, op2, cmd
    );

endinterface

// File: source/ialu_adder.sv
// ALU main adder
// Adds for ADD and subtracts for every other command, flags from the result

`include "ialu_cfg.svh"

module ialu_adder (
    ialu_req_if.unit                req,
    output logic [`IALU_XLEN-1:0]   sum,
    output ialu_pkg::ialu_flags_s   flags
);

    localparam int MSB = `IALU_XLEN - 1;

    logic                   sub;
    logic [`IALU_XLEN:0]    sum_ext;    // Extra bit holds carry or borrow
    logic                   a_msb;
    logic                   b_msb;
    logic                   r_msb;

    // ------------------------------------------------------------------------
    // Add / subtract
    // ------------------------------------------------------------------------
    always_comb begin
        sub     = (req.cmd != ialu_pkg::ADD);
        sum_ext = sub ? ({1'b0, req.op1} - {1'b0, req.op2})
                      : ({1'b0, req.op1} + {1'b0, req.op2});
    end

    assign sum   = sum_ext[MSB:0];
    assign a_msb = req.op1[MSB];
    assign b_msb = req.op2[MSB];
    assign r_msb = sum_ext[MSB];

    // ------------------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------------------
    always_comb begin
        flags.carry = sum_ext[`IALU_XLEN];
        flags.zero  = ~|sum_ext[MSB:0];
        flags.sign  = r_msb;
        // Operand signs differ on sub, agree on add, and the result flips sign
        flags.overflow = (sub ? (a_msb ^ b_msb) : ~(a_msb ^ b_msb)) & (a_msb ^ r_msb);
    end

endmodule

// File: source/ialu_logic_shift.sv
// ALU bitwise logic and barrel shifter
// AND/OR/XOR of both operands, op1 shifted by the low bits of op2

`include "ialu_cfg.svh"

module ialu_logic_shift (
    ialu_req_if.unit                req,
    output logic [`IALU_XLEN-1:0]   logic_res,
    output logic [`IALU_XLEN-1:0]   shift_res
);

    logic [`IALU_SHAMT_W-1:0]   shamt;

    assign shamt = req.op2[`IALU_SHAMT_W-1:0];

    always_comb begin
        case (req.cmd)
            ialu_pkg::OR  : logic_res = req.op1 | req.op2;
            ialu_pkg::XOR : logic_res = req.op1 ^ req.op2;
            default       : logic_res = req.op1 & req.op2;
        endcase
    end

    always_comb begin
        case (req.cmd)
            ialu_pkg::SRL : shift_res = req.op1 >> shamt;
            ialu_pkg::SRA : shift_res = $unsigned($signed(req.op1) >>> shamt);
            default       : shift_res = req.op1 << shamt;
        endcase
    end

endmodule

// File: source/ialu_mul_seq.sv
// Sequential shift-and-add multiplier
// One op2 bit per cycle, 32 steps, high or low word of the product

`include "ialu_cfg.svh"

module ialu_mul_seq (
    input  logic                    clk,
    input  logic                    rst_n,
    ialu_req_if.unit                req,
    input  logic                    mul_en,
    output logic [`IALU_XLEN-1:0]   mul_res,
    output logic                    rdy
);

    localparam int XLEN = `IALU_XLEN;
    localparam logic [`IALU_MUL_CNT_W-1:0] MUL_INIT_CNT = `IALU_MUL_CNT_W'(XLEN - 2);

    typedef enum logic {
        ST_IDLE,
        ST_ITER
    } mul_state_e;

    mul_state_e                 state;
    logic [`IALU_MUL_CNT_W-1:0] cnt;
    logic [XLEN-1:0]            hi_reg;     // High part of partial product
    logic [XLEN-1:0]            lo_reg;     // Low part / remaining op2 bits

    logic                       op1_signed;
    logic                       op2_signed;
    logic                       iter_req;
    logic                       iter_last;
    logic                       mul_bit;
    logic [XLEN:0]              mcand;      // Sign-extended multiplicand
    logic [XLEN:0]              acc;
    logic [XLEN:0]              step_sum;
    logic [XLEN-1:0]            hi_nxt;
    logic [XLEN-1:0]            lo_nxt;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    assign op1_signed = (req.cmd == ialu_pkg::MULH) | (req.cmd == ialu_pkg::MULHSU);
    assign op2_signed = (req.cmd == ialu_pkg::MULH);
    assign iter_req   = mul_en & |req.op1 & |req.op2 & (state == ST_IDLE);
    assign iter_last  = (state == ST_ITER) & (cnt == '0);
    assign rdy        = (state == ST_IDLE) ? ~iter_req : iter_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else if (!req.vd) begin
            state <= ST_IDLE;                   // Abort on dropped valid
        end else if (iter_req) begin
            state <= ST_ITER;
        end else if (iter_last) begin
            state <= ST_IDLE;
        end
    end

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    always_comb begin
        mul_bit  = (state == ST_IDLE) ? req.op2[0] : lo_reg[0];
        mcand    = mul_bit ? {op1_signed & req.op1[XLEN-1], req.op1} : '0;
        acc      = (state == ST_IDLE) ? '0 : {op1_signed & hi_reg[XLEN-1], hi_reg};
        // Last bit of a signed op2 carries weight -2^31
        step_sum = (op2_signed & iter_last) ? (acc - mcand) : (acc + mcand);
        hi_nxt   = step_sum[XLEN:1];
        lo_nxt   = {step_sum[0], (state == ST_IDLE) ? req.op2[XLEN-1:1] : lo_reg[XLEN-1:1]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (req.vd & ~rdy) begin
            cnt <= (state == ST_IDLE) ? MUL_INIT_CNT : cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.vd & ~rdy) begin
            hi_reg <= hi_nxt;
            lo_reg <= lo_nxt;
        end
    end

    // Zero operand finishes in idle with a zero result
    always_comb begin
        if (state == ST_IDLE) begin
            mul_res = '0;
        end else if (req.cmd == ialu_pkg::MUL) begin
            mul_res = lo_nxt;
        end else begin
            mul_res = hi_nxt;
        end
    end

endmodule

// File: source/ialu_result_sel.sv
// ALU result select
// Command group decode, compare evaluation and result multiplexing

`include "ialu_cfg.svh"

module ialu_result_sel (
    ialu_req_if.unit                req,
    input  logic [`IALU_XLEN-1:0]   sum,
    input  ialu_pkg::ialu_flags_s   flags,
    input  logic [`IALU_XLEN-1:0]   logic_res,
    input  logic [`IALU_XLEN-1:0]   shift_res,
    input  logic [`IALU_XLEN-1:0]   mul_res,
    input  logic                    mul_rdy,
    output logic                    mul_en,
    output logic [`IALU_XLEN-1:0]   res,
    output logic                    cmp,
    output logic                    rdy
);

    logic lt;   // Signed less than

    assign lt = flags.sign ^ flags.overflow;

    assign mul_en = (req.cmd == ialu_pkg::MUL)    | (req.cmd == ialu_pkg::MULH) |
                    (req.cmd == ialu_pkg::MULHSU) | (req.cmd == ialu_pkg::MULHU);

    assign rdy = mul_rdy;       // High for every single-cycle command

    // ------------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------------
    always_comb begin
        case (req.cmd)
            ialu_pkg::SUB_LT  : cmp = lt;
            ialu_pkg::SUB_LTU : cmp = flags.carry;
            ialu_pkg::SUB_EQ  : cmp = flags.zero;
            ialu_pkg::SUB_NE  : cmp = ~flags.zero;
            ialu_pkg::SUB_GE  : cmp = ~lt;
            ialu_pkg::SUB_GEU : cmp = ~flags.carry;
            default           : cmp = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------
    always_comb begin
        case (req.cmd)
            ialu_pkg::ADD, ialu_pkg::SUB : res = sum;
            ialu_pkg::SUB_LT, ialu_pkg::SUB_LTU, ialu_pkg::SUB_EQ,
            ialu_pkg::SUB_NE, ialu_pkg::SUB_GE, ialu_pkg::SUB_GEU :
                res = `IALU_XLEN'(cmp);                         // Zero-extended compare
            ialu_pkg::AND, ialu_pkg::OR, ialu_pkg::XOR : res = logic_res;
            ialu_pkg::SLL, ialu_pkg::SRL, ialu_pkg::SRA : res = shift_res;
            default : res = mul_en ? mul_res : '0;
        endcase
    end

endmodule

// File: source/ialu_top.sv
// Integer ALU top level
// Adder, logic/shift, sequential multiplier and result select

`include "ialu_cfg.svh"

module ialu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vd,
    input  logic [`IALU_XLEN-1:0]   op1,
    input  logic [`IALU_XLEN-1:0]   op2,
    input  ialu_pkg::ialu_cmd_e     cmd,
    output logic [`IALU_XLEN-1:0]   res,
    output logic                    cmp,
    output logic                    rdy
);

    logic [`IALU_XLEN-1:0]  sum;
    ialu_pkg::ialu_flags_s  flags;
    logic [`IALU_XLEN-1:0]  logic_res;
    logic [`IALU_XLEN-1:0]  shift_res;
    logic [`IALU_XLEN-1:0]  mul_res;
    logic                   mul_rdy;
    logic                   mul_en;

    ialu_req_if req_if ();

    assign req_if.vd  = vd;
    assign req_if.op1 = op1;
    assign req_if.op2 = op2;
    assign req_if.cmd = cmd;

    ialu_adder i_adder (.req(req_if.unit), .sum(sum), .flags(flags));

    ialu_logic_shift i_logic_shift (
        .req(req_if.unit), .logic_res(logic_res), .shift_res(shift_res)
    );

    ialu_mul_seq i_mul_seq (
        .clk(clk), .rst_n(rst_n), .req(req_if.unit), .mul_en(mul_en),
        .mul_res(mul_res), .rdy(mul_rdy)
    );

    ialu_result_sel i_result_sel (
        .req(req_if.unit), .sum(sum), .flags(flags), .logic_res(logic_res),
        .shift_res(shift_res), .mul_res(mul_res), .mul_rdy(mul_rdy),
        .mul_en(mul_en), .res(res), .cmp(cmp), .rdy(rdy)
    );

endmodule

// File: sim/ialu_mul_checker.sv
// Multiplier FSM checker
// Start, iteration and abort rules of the sequential multiplier

`include "ialu_cfg.svh"

module ialu_mul_checker (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         state,      // 0 idle, 1 iterating
    input logic [`IALU_MUL_CNT_W-1:0]   cnt,
    input logic                         vd,
    input logic                         mul_en,
    input logic [`IALU_XLEN-1:0]        op1,
    input logic [`IALU_XLEN-1:0]        op2
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic IDLE = 1'b0;
    localparam logic ITER = 1'b1;

    int fail_cnt = 0;       // Read by the testbench

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({state, vd}))
    else begin
        fail_cnt++;
        $error("Multiplier state or vd is unknown");
    end

    a_start: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE && vd && mul_en && |op1 && |op2) |=> (state == ITER))
    else begin
        fail_cnt++;
        $error("Multiply with nonzero operands did not start iterating");
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ITER && vd && cnt != '0) |=> (state == ITER))
    else begin
        fail_cnt++;
        $error("Multiplier left ITER before the counter reached zero");
    end

    a_abort: assert property (@(posedge clk) disable iff (!rst_n)
        !vd |=> (state == IDLE))
    else begin
        fail_cnt++;
        $error("Multiplier not idle one cycle after vd dropped");
    end

endmodule

bind ialu_mul_seq ialu_mul_checker i_mul_checker (
    .clk(clk), .rst_n(rst_n), .state(state), .cnt(cnt), .vd(req.vd),
    .mul_en(mul_en), .op1(req.op1), .op2(req.op2)
);

// File: sim/ialu_tb.sv
// Integer ALU testbench
// Random and edge operands through every command, multiplier latency and abort

`include "ialu_cfg.svh"

module ialu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int              XLEN       = `IALU_XLEN;
    localparam int              T_CLK      = 40;
    localparam int              N_RAND     = 20;
    localparam int              MUL_CYCLES = 32;
    localparam int              N_OPS      = 8 * N_RAND + 10 * (N_RAND + 4) + 8 + 2;
    localparam int              WDOG_CYC   = N_OPS * 34 + 10;
    localparam logic [XLEN-1:0] MIN        = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] MAX        = ~MIN;
    localparam logic [XLEN-1:0] NEG1       = '1;

    logic                   clk;
    logic                   rst_n;
    logic                   vd;
    logic [XLEN-1:0]        op1;
    logic [XLEN-1:0]        op2;
    ialu_pkg::ialu_cmd_e    cmd;
    logic [XLEN-1:0]        res;
    logic                   cmp;
    logic                   rdy;

    string  test_name;
    integer seed = 32'hdb59_c4ef;
    int     err_res = 0;
    int     err_cmp = 0;
    int     err_lat = 0;

    ialu_pkg::ialu_cmd_e alu_cmds[8] = '{ialu_pkg::ADD, ialu_pkg::SUB, ialu_pkg::AND,
        ialu_pkg::OR, ialu_pkg::XOR, ialu_pkg::SLL, ialu_pkg::SRL, ialu_pkg::SRA};
    ialu_pkg::ialu_cmd_e cmp_cmds[6] = '{ialu_pkg::SUB_LT, ialu_pkg::SUB_LTU,
        ialu_pkg::SUB_EQ, ialu_pkg::SUB_NE, ialu_pkg::SUB_GE, ialu_pkg::SUB_GEU};
    ialu_pkg::ialu_cmd_e mul_cmds[4] = '{ialu_pkg::MUL, ialu_pkg::MULH,
        ialu_pkg::MULHSU, ialu_pkg::MULHU};
    logic [2*XLEN-1:0] cmp_edges[4] = '{{MAX, MAX}, {MIN, MAX}, {MAX, MIN}, {{XLEN{1'b0}}, NEG1}};
    logic [2*XLEN-1:0] mul_edges[4] = '{{MIN, MIN}, {NEG1, NEG1}, {MIN, MAX}, {MAX, NEG1}};

    ialu_top i_ialu_top (
        .clk(clk), .rst_n(rst_n), .vd(vd), .op1(op1), .op2(op2), .cmd(cmd),
        .res(res), .cmp(cmp), .rdy(rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(T_CLK / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference model, returns {cmp, res}
    // ------------------------------------------------------------------------
    function automatic logic [XLEN:0] ref_alu(input ialu_pkg::ialu_cmd_e c,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]          a_s;
        logic [2*XLEN-1:0]          b_s;
        logic [2*XLEN-1:0]          prod;
        logic [XLEN-1:0]            r;
        logic                       c_bit;
        logic [`IALU_SHAMT_W-1:0]   sh;
        a_s   = {{XLEN{a[XLEN-1]}}, a};
        b_s   = {{XLEN{b[XLEN-1]}}, b};
        sh    = b[`IALU_SHAMT_W-1:0];
        r     = '0;
        c_bit = 1'b0;
        case (c)
            ialu_pkg::MULH   : prod = a_s * b_s;
            ialu_pkg::MULHSU : prod = a_s * {{XLEN{1'b0}}, b};
            default          : prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        endcase
        case (c)
            ialu_pkg::ADD     : r = a + b;
            ialu_pkg::SUB     : r = a - b;
            ialu_pkg::AND     : r = a & b;
            ialu_pkg::OR      : r = a | b;
            ialu_pkg::XOR     : r = a ^ b;
            ialu_pkg::SLL     : r = a << sh;
            ialu_pkg::SRL     : r = a >> sh;
            ialu_pkg::SRA     : r = $signed(a) >>> sh;
            ialu_pkg::SUB_LT  : c_bit = $signed(a) < $signed(b);
            ialu_pkg::SUB_LTU : c_bit = a < b;
            ialu_pkg::SUB_EQ  : c_bit = (a == b);
            ialu_pkg::SUB_NE  : c_bit = (a != b);
            ialu_pkg::SUB_GE  : c_bit = $signed(a) >= $signed(b);
            ialu_pkg::SUB_GEU : c_bit = a >= b;
            ialu_pkg::MUL     : r = prod[XLEN-1:0];
            ialu_pkg::MULH, ialu_pkg::MULHSU, ialu_pkg::MULHU : r = prod[2*XLEN-1:XLEN];
            default           : r = '0;
        endcase
        if (c_bit) begin
            r = XLEN'(1);       // Compare bit zero-extended
        end
        return {c_bit, r};
    endfunction

    task automatic check_res(input string name, input logic [XLEN-1:0] want,
                             input logic [XLEN-1:0] got);
        if (got !== want) begin
            err_res++;
            $display("Error %s res: expected %h, actual %h", name, want, got);
        end
    endtask

    task automatic check_cmp(input string name, input logic want, input logic got);
        if (got !== want) begin
            err_cmp++;
            $display("Error %s cmp: expected %b, actual %b", name, want, got);
        end
    endtask

    task automatic check_cycles(input string name, input int want, input int got);
        if (got != want) begin
            err_lat++;
            $display("Error %s latency: expected %0d, actual %0d", name, want, got);
        end
    endtask

    // Results are taken where vd and rdy meet
    always @(posedge clk) begin
        logic [XLEN:0] want;
        if (rst_n && vd && rdy) begin
            want = ref_alu(cmd, op1, op2);
            check_res($sformatf("%s/%s", test_name, cmd.name()), want[XLEN-1:0], res);
            if (cmd inside {ialu_pkg::SUB_LT, ialu_pkg::SUB_LTU, ialu_pkg::SUB_EQ,
                            ialu_pkg::SUB_NE, ialu_pkg::SUB_GE, ialu_pkg::SUB_GEU}) begin
                check_cmp($sformatf("%s/%s", test_name, cmd.name()), want[XLEN], cmp);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic run_op(input string name, input ialu_pkg::ialu_cmd_e c,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int cycles;
        int want;
        @(negedge clk);
        test_name = name;
        vd        = 1'b1;
        cmd       = c;
        op1       = a;
        op2       = b;
        want      = (c inside {mul_cmds} && a != '0 && b != '0) ? MUL_CYCLES : 1;
        cycles    = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (rdy !== 1'b1 && cycles < MUL_CYCLES + 8);
        check_cycles($sformatf("%s/%s", name, c.name()), want, cycles);
    endtask

    // Start a multiply and drop vd part way through
    task automatic abort_mul(input ialu_pkg::ialu_cmd_e c, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        @(negedge clk);
        test_name = "abort_mul";
        vd        = 1'b1;
        cmd       = c;
        op1       = a;
        op2       = b;
        repeat (10) @(posedge clk);
        @(negedge clk);
        vd = 1'b0;
        @(posedge clk);
    endtask

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              err_asrt;
        rst_n = 1'b0;
        vd    = 1'b0;
        op1   = '0;
        op2   = '0;
        cmd   = ialu_pkg::NONE;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (alu_cmds[i]) begin
            repeat (N_RAND) begin
                a = $random(seed);
                b = $random(seed);
                run_op("alu_rand", alu_cmds[i], a, b);
            end
        end
        foreach (cmp_cmds[i]) begin
            repeat (N_RAND) begin
                a = $random(seed);
                b = $random(seed);
                run_op("cmp_rand", cmp_cmds[i], a, b);
            end
            foreach (cmp_edges[j]) begin
                run_op("cmp_edge", cmp_cmds[i], cmp_edges[j][2*XLEN-1:XLEN],
                       cmp_edges[j][XLEN-1:0]);
            end
        end
        foreach (mul_cmds[i]) begin
            repeat (N_RAND) begin
                a = $random(seed);
                b = $random(seed);
                run_op("mul_rand", mul_cmds[i], a, b);
            end
            foreach (mul_edges[j]) begin
                run_op("mul_edge", mul_cmds[i], mul_edges[j][2*XLEN-1:XLEN],
                       mul_edges[j][XLEN-1:0]);
            end
            a = $random(seed);
            run_op("mul_zero", mul_cmds[i], '0, a);
            run_op("mul_zero", mul_cmds[i], a, '0);
        end
        a = $random(seed);
        b = $random(seed);
        abort_mul(ialu_pkg::MULH, a | 1, b | 1);
        run_op("abort_add", ialu_pkg::ADD, a, b);

        @(negedge clk);
        vd = 1'b0;
        repeat (2) @(posedge clk);
        err_asrt = i_ialu_top.i_mul_seq.i_mul_checker.fail_cnt;
        $display("Errors: result %0d, compare %0d, latency %0d, assertion %0d",
                 err_res, err_cmp, err_lat, err_asrt);
        if (err_res + err_cmp + err_lat + err_asrt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYC * T_CLK);
        $display("Timeout: the DUT did not finish all operations in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/ialu_pkg.sv
source/ialu_req_if.sv
source/ialu_adder.sv
source/ialu_logic_shift.sv
source/ialu_mul_seq.sv
source/ialu_result_sel.sv
source/ialu_top.sv
sim/ialu_mul_checker.sv
sim/ialu_tb.sv

// File: Bender.yml
package:
  name: ialu

export_include_dirs:
  - source

sources:
  - files:
      - source/ialu_pkg.sv
      - source/ialu_req_if.sv
      - source/ialu_adder.sv
      - source/ialu_logic_shift.sv
      - source/ialu_mul_seq.sv
      - source/ialu_result_sel.sv
      - source/ialu_top.sv
  - target: simulation
    files:
      - sim/ialu_mul_checker.sv
      - sim/ialu_tb.sv
